// ==== hdl/dram_scrub_pkg.sv ====
package dram_scrub_pkg;

   // ------------------------------------------------------------------
   // card geometry
   // ------------------------------------------------------------------

   localparam int NUM_DDR = 4;

   // bytes moved per data beat on one DDR channel
   localparam int DDR_BEAT_BYTES = 64;

   typedef logic [63:0] ddr_addr_t;
   typedef logic [31:0] ctl_word_t;
   typedef logic [31:0] id_word_t;

   // ------------------------------------------------------------------
   // control word layout
   // ------------------------------------------------------------------

   // bits NUM_DDR-1:0 are the per-channel scrub enables
   localparam int CTL_DBG_EN_BIT  = 31;
   localparam int CTL_DBG_SEL_LSB = 28;
   localparam int CTL_DBG_SEL_W   = 3;

   // id words shown while the debug readout is off
   localparam id_word_t CARD_ID0 = 32'hC0DE_0A01;
   localparam id_word_t CARD_ID1 = 32'hC0DE_0B02;

   // scrubber sequencer states
   typedef enum logic [1:0]
   {
      SCRB_IDLE = 2'd0,
      SCRB_RUN  = 2'd1,
      SCRB_DONE = 2'd2
   } scrb_state_t;

endpackage

// ==== hdl/scrub_if.sv ====
// one channel's scrub control and status
interface scrub_if import dram_scrub_pkg::*; ();

   logic      enable;
   logic      ddr_ready;
   ddr_addr_t addr;
   logic      done;

   modport ctl
   (
      output enable,
      output ddr_ready
   );

   modport scrubber
   (
      input  enable,
      input  ddr_ready,
      output addr,
      output done
   );

   modport readout
   (
      input addr,
      input done
   );

endinterface

// ==== hdl/shell_ctl_regs.sv ====
module shell_ctl_regs import dram_scrub_pkg::*;
(
   input  logic                     clk,
   input  logic                     sync_rst_n,
   input  ctl_word_t                ctl0,
   input  logic [NUM_DDR-1:0]       ddr_is_ready,
   input  logic                     flr_assert,
   output logic                     flr_done,
   output logic                     dbg_en,
   output logic [CTL_DBG_SEL_W-1:0] dbg_sel,
   scrub_if.ctl                     chan [NUM_DDR]
);

   ctl_word_t          ctl_q;
   logic [NUM_DDR-1:0] ready_q;
   logic               flr_assert_q;

   // ------------------------------------------------------------------
   // control word and ready levels from the shell
   // ------------------------------------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl_q   <= '0;
         ready_q <= '0;
      end
      else
      begin
         ctl_q   <= ctl0;
         ready_q <= ddr_is_ready;
      end
   end

   // debug fields in the top bits
   assign dbg_en  = ctl_q[CTL_DBG_EN_BIT];
   assign dbg_sel = ctl_q[CTL_DBG_SEL_LSB +: CTL_DBG_SEL_W];

   // one enable bit and one ready level per channel
   for (genvar i = 0; i < NUM_DDR; i++)
   begin : g_chan
      assign chan[i].enable    = ctl_q[i];
      assign chan[i].ddr_ready = ready_q[i];
   end

   // ------------------------------------------------------------------
   // function level reset responder
   // ------------------------------------------------------------------

   // done pulses for one cycle, then rests a cycle while assert is held
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

endmodule

// ==== hdl/ddr_scrubber.sv ====
module ddr_scrubber import dram_scrub_pkg::*;
#(
   parameter ddr_addr_t SCRB_MAX_ADDR         = 64'h1FFF,
   parameter int        SCRB_BURST_LEN_MINUS1 = 15
)
(
   input  logic     clk,
   input  logic     sync_rst_n,
   scrub_if.scrubber chan
);

   // bytes covered by one burst
   localparam ddr_addr_t BURST_BYTES =
      ddr_addr_t'((SCRB_BURST_LEN_MINUS1 + 1) * DDR_BEAT_BYTES);

   scrb_state_t state;
   ddr_addr_t   addr_q;
   ddr_addr_t   next_addr;
   logic        last_burst;
   logic        done_q;

   // start of the following burst
   assign next_addr  = addr_q + BURST_BYTES;
   assign last_burst = next_addr > SCRB_MAX_ADDR;

   // ------------------------------------------------------------------
   // sequencer
   // ------------------------------------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         state  <= SCRB_IDLE;
         addr_q <= '0;
         done_q <= 1'b0;
      end
      else if (!chan.enable)
      begin
         // dropping enable abandons the walk from any state
         state  <= SCRB_IDLE;
         addr_q <= '0;
         done_q <= 1'b0;
      end
      else
      begin
         case (state)
            SCRB_IDLE:
            begin
               addr_q <= '0;
               done_q <= 1'b0;
               state  <= SCRB_RUN;
            end
            SCRB_RUN:
            begin
               // not ready means hold the current burst
               if (chan.ddr_ready)
               begin
                  if (last_burst)
                  begin
                     state  <= SCRB_DONE;
                     done_q <= 1'b1;
                  end
                  else
                  begin
                     addr_q <= next_addr;
                  end
               end
            end
            SCRB_DONE:
            begin
               // parked on the final burst until enable goes low
               done_q <= 1'b1;
            end
            default:
            begin
               state  <= SCRB_IDLE;
               addr_q <= '0;
               done_q <= 1'b0;
            end
         endcase
      end
   end

   assign chan.addr = addr_q;
   assign chan.done = done_q;

endmodule

// ==== hdl/scrub_debug_mux.sv ====
module scrub_debug_mux import dram_scrub_pkg::*;
(
   input  logic                     clk,
   input  logic                     sync_rst_n,
   input  logic                     dbg_en,
   input  logic [CTL_DBG_SEL_W-1:0] dbg_sel,
   scrub_if.readout                 chan [NUM_DDR],
   output id_word_t                 id0,
   output id_word_t                 id1,
   output logic [NUM_DDR-1:0]       scrb_done
);

   ddr_addr_t          chan_addr [NUM_DDR];
   logic [NUM_DDR-1:0] done_vec;
   ddr_addr_t          sel_addr;

   // flatten the interface array
   for (genvar i = 0; i < NUM_DDR; i++)
   begin : g_chan
      assign chan_addr[i] = chan[i].addr;
      assign done_vec[i]  = chan[i].done;
   end

   // out of range selects read channel 0
   always_comb
   begin
      sel_addr = chan_addr[0];
      for (int i = 1; i < NUM_DDR; i++)
      begin
         if (dbg_sel == CTL_DBG_SEL_W'(i))
            sel_addr = chan_addr[i];
      end
   end

   // ------------------------------------------------------------------
   // id outputs
   // ------------------------------------------------------------------

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         id0 <= CARD_ID0;
         id1 <= CARD_ID1;
      end
      else if (dbg_en)
      begin
         id0 <= sel_addr[31:0];
         id1 <= sel_addr[63:32];
      end
      else
      begin
         id0 <= CARD_ID0;
         id1 <= CARD_ID1;
      end
   end

   assign scrb_done = done_vec;

endmodule

// ==== hdl/dram_scrub_top.sv ====
module dram_scrub_top import dram_scrub_pkg::*;
#(
   parameter ddr_addr_t SCRB_MAX_ADDR         = 64'h1FFF,
   parameter int        SCRB_BURST_LEN_MINUS1 = 15
)
(
   input  logic               clk,
   input  logic               sync_rst_n,
   input  ctl_word_t          ctl0,
   input  logic [NUM_DDR-1:0] ddr_is_ready,
   input  logic               flr_assert,
   output logic               flr_done,
   output id_word_t           id0,
   output id_word_t           id1,
   output logic [NUM_DDR-1:0] scrb_done
);

   logic                     dbg_en;
   logic [CTL_DBG_SEL_W-1:0] dbg_sel;

   // one bundle per DDR channel
   scrub_if chan [NUM_DDR] ();

   // ------------------------------------------------------------------
   // control register and FLR response
   // ------------------------------------------------------------------

   shell_ctl_regs u_ctl_regs
   (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .ctl0         (ctl0),
      .ddr_is_ready (ddr_is_ready),
      .flr_assert   (flr_assert),
      .flr_done     (flr_done),
      .dbg_en       (dbg_en),
      .dbg_sel      (dbg_sel),
      .chan         (chan)
   );

   // ------------------------------------------------------------------
   // per channel scrubbers
   // ------------------------------------------------------------------

   for (genvar i = 0; i < NUM_DDR; i++)
   begin : g_scrb
      ddr_scrubber
      #(
         .SCRB_MAX_ADDR         (SCRB_MAX_ADDR),
         .SCRB_BURST_LEN_MINUS1 (SCRB_BURST_LEN_MINUS1)
      )
      u_scrubber
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .chan       (chan[i])
      );
   end

   // debug readout onto the id words
   scrub_debug_mux u_debug_mux
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .dbg_en     (dbg_en),
      .dbg_sel    (dbg_sel),
      .chan       (chan),
      .id0        (id0),
      .id1        (id1),
      .scrb_done  (scrb_done)
   );

endmodule

// ==== dv/dram_scrub_tb.sv ====
module dram_scrub_tb import dram_scrub_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   // must track the DUT defaults
   localparam ddr_addr_t MAX_ADDR         = 64'h1FFF;
   localparam int        BURST_LEN_MINUS1 = 15;
   // a few hundred cycles are expected, stalls included
   localparam int        TIMEOUT_CYCLES   = 2000;
   localparam int        WAIT_LIMIT       = 200;

   logic               clk;
   logic               sync_rst_n;
   ctl_word_t          ctl0;
   logic [NUM_DDR-1:0] ddr_is_ready;
   logic               flr_assert;
   logic               flr_done;
   id_word_t           id0;
   id_word_t           id1;
   logic [NUM_DDR-1:0] scrb_done;

   // expected values handed to the compare process
   id_word_t           exp_id0;
   id_word_t           exp_id1;
   logic [NUM_DDR-1:0] exp_done;
   logic               exp_flr;
   logic               cmp_req;

   // debug address watch during the stall runs
   logic               mono_on;
   ddr_addr_t          mono_prev;

   int                 mismatch_count;
   int                 other_count;
   int                 cycle_count;

   dram_scrub_top UUT
   (
      .clk          (clk),
      .sync_rst_n   (sync_rst_n),
      .ctl0         (ctl0),
      .ddr_is_ready (ddr_is_ready),
      .flr_assert   (flr_assert),
      .flr_done     (flr_done),
      .id0          (id0),
      .id1          (id1),
      .scrb_done    (scrb_done)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ----------------------------------------------------------------------
   // reference model
   // ----------------------------------------------------------------------

   function automatic ddr_addr_t burst_bytes();
      return ddr_addr_t'(BURST_LEN_MINUS1 + 1) * ddr_addr_t'(DDR_BEAT_BYTES);
   endfunction

   // bursts needed to cover 0 up to MAX_ADDR
   function automatic int ref_burst_count();
      return int'((MAX_ADDR + 64'd1) / burst_bytes());
   endfunction

   // a finished scrubber parks on the start of its final burst
   function automatic ddr_addr_t ref_last_addr();
      return ddr_addr_t'(ref_burst_count() - 1) * burst_bytes();
   endfunction

   function automatic ctl_word_t make_ctl(input logic dbg, input int sel,
                                          input logic [NUM_DDR-1:0] en);
      ctl_word_t w;
      w = '0;
      w[CTL_DBG_EN_BIT] = dbg;
      w[CTL_DBG_SEL_LSB +: CTL_DBG_SEL_W] = CTL_DBG_SEL_W'(sel);
      w[NUM_DDR-1:0] = en;
      return w;
   endfunction

   // ----------------------------------------------------------------------
   // compare tasks and process
   // ----------------------------------------------------------------------

   task automatic check_id(input string name, input id_word_t exp, input id_word_t act);
      if (act !== exp)
      begin
         $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
         mismatch_count++;
      end
   endtask

   task automatic check_done(input string name, input logic [NUM_DDR-1:0] exp,
                             input logic [NUM_DDR-1:0] act);
      if (act !== exp)
      begin
         $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
         mismatch_count++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("MISMATCH at %0t: %s expected %b, got %b", $time, name, exp, act);
         mismatch_count++;
      end
   endtask

   initial
   begin
      forever
      begin
         wait (cmp_req === 1'b1);
         check_id("id0", exp_id0, id0);
         check_id("id1", exp_id1, id1);
         check_done("scrb_done", exp_done, scrb_done);
         check_bit("flr_done", exp_flr, flr_done);
         cmp_req = 1'b0;
      end
   end

   // address of the selected channel must only climb while enabled
   always @(negedge clk)
   begin
      if (mono_on === 1'b1)
      begin
         if ({id1, id0} < mono_prev)
         begin
            $display("at %0t the debug address went down from %h to %h",
                     $time, mono_prev, {id1, id0});
            other_count++;
         end
         mono_prev = {id1, id0};
      end
   end

   // ----------------------------------------------------------------------
   // stimulus helpers
   // ----------------------------------------------------------------------

   task automatic expect_outputs(input id_word_t e0, input id_word_t e1,
                                 input logic [NUM_DDR-1:0] ed, input logic ef);
      exp_id0  = e0;
      exp_id1  = e1;
      exp_done = ed;
      exp_flr  = ef;
      cmp_req  = 1'b1;
      wait (cmp_req === 1'b0);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   // optionally stalls ready at random while waiting
   task automatic wait_for_done(input logic [NUM_DDR-1:0] mask, input logic stall);
      int          n;
      logic [31:0] r;
      n = 0;
      while (((scrb_done & mask) != mask) && (n < WAIT_LIMIT))
      begin
         @(negedge clk);
         if (stall)
         begin
            r = $urandom;
            ddr_is_ready = r[NUM_DDR-1:0];
         end
         n++;
      end
      if ((scrb_done & mask) != mask)
      begin
         $display("channels %b never reported done within %0d cycles", mask, WAIT_LIMIT);
         other_count++;
      end
   endtask

   // ----------------------------------------------------------------------
   // test sequence
   // ----------------------------------------------------------------------

   initial
   begin
      ddr_addr_t          last;
      logic [NUM_DDR-1:0] en;
      void'($urandom(43));
      sync_rst_n     = 1'b0;
      ctl0           = '0;
      ddr_is_ready   = '0;
      flr_assert     = 1'b0;
      cmp_req        = 1'b0;
      mono_on        = 1'b0;
      mono_prev      = '0;
      mismatch_count = 0;
      other_count    = 0;
      last           = ref_last_addr();
      repeat (3) @(negedge clk);
      sync_rst_n = 1'b1;
      expect_outputs(CARD_ID0, CARD_ID1, '0, 1'b0);

      // one cycle FLR pulse, done expected on the second edge only
      @(negedge clk);
      flr_assert = 1'b1;
      @(negedge clk);
      flr_assert = 1'b0;
      expect_outputs(CARD_ID0, CARD_ID1, '0, 1'b0);
      for (int i = 0; i < 4; i++)
      begin
         @(negedge clk);
         expect_outputs(CARD_ID0, CARD_ID1, '0, i == 0);
      end

      // one channel at a time, all ready
      ddr_is_ready = '1;
      for (int ch = 0; ch < NUM_DDR; ch++)
      begin
         en = '0;
         en[ch] = 1'b1;
         ctl0 = make_ctl(1'b1, ch, en);
         wait_for_done(en, 1'b0);
         @(negedge clk);
         expect_outputs(last[31:0], last[63:32], en, 1'b0);
         ctl0 = '0;
         idle_cycles(3);
         expect_outputs(CARD_ID0, CARD_ID1, '0, 1'b0);
      end

      // all channels with random stalls, watching each channel in turn
      for (int k = 0; k < NUM_DDR; k++)
      begin
         ctl0 = make_ctl(1'b1, k, '0);
         idle_cycles(3);
         expect_outputs('0, '0, '0, 1'b0);
         mono_prev = '0;
         mono_on   = 1'b1;
         ctl0 = make_ctl(1'b1, k, '1);
         wait_for_done('1, 1'b1);
         ddr_is_ready = '1;
         @(negedge clk);
         mono_on = 1'b0;
         expect_outputs(last[31:0], last[63:32], '1, 1'b0);
      end

      // drop the enables one by one
      en = '1;
      for (int c = 0; c < NUM_DDR; c++)
      begin
         en[c] = 1'b0;
         ctl0 = make_ctl(1'b1, c, en);
         idle_cycles(3);
         expect_outputs('0, '0, en, 1'b0);
      end

      // out of range selects fall back to channel 0
      en = '0;
      en[0] = 1'b1;
      ctl0 = make_ctl(1'b0, 0, en);
      wait_for_done(en, 1'b0);
      for (int s = NUM_DDR; s < (1 << CTL_DBG_SEL_W); s++)
      begin
         ctl0 = make_ctl(1'b1, s, en);
         idle_cycles(2);
         expect_outputs(last[31:0], last[63:32], en, 1'b0);
      end
      ctl0 = make_ctl(1'b0, 0, en);
      @(negedge clk);
      expect_outputs(last[31:0], last[63:32], en, 1'b0);
      @(negedge clk);
      expect_outputs(CARD_ID0, CARD_ID1, en, 1'b0);

      idle_cycles(2);
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
      if ((mismatch_count + other_count) == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

   // run limit
   initial
   begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      other_count++;
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
      $display("test failed");
      $finish;
   end

endmodule

// ==== project.f ====
hdl/dram_scrub_pkg.sv
hdl/scrub_if.sv
hdl/shell_ctl_regs.sv
hdl/ddr_scrubber.sv
hdl/scrub_debug_mux.sv
hdl/dram_scrub_top.sv
dv/dram_scrub_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = dram_scrub_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
